//--- src.f
+incdir+tests
logic/cpuPkg.sv
logic/stageReg.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/memoryStage.sv
logic/hazardUnit.sv
logic/cpu.sv
tests/cpuTb.sv

//--- tests/cpuAsm.svh
`ifndef CPU_ASM_SVH
`define CPU_ASM_SVH

// RV32I field packing, register numbers and immediates taken as int
function automatic logic [31:0] rType(input int funct7, input int rd, input int rs1,
                                      input int rs2, input int funct3);
    return {funct7[6:0], rs2[4:0], rs1[4:0], funct3[2:0], rd[4:0], 7'b0110011};
endfunction

function automatic logic [31:0] iType(input int opcode, input int rd, input int rs1,
                                      input int imm, input int funct3);
    return {imm[11:0], rs1[4:0], funct3[2:0], rd[4:0], opcode[6:0]};
endfunction

function automatic logic [31:0] bType(input int rs1, input int rs2, input int off,
                                      input int funct3);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], funct3[2:0], off[4:1], off[11],
            7'b1100011};
endfunction

function automatic logic [31:0] lui(input int rd, input int imm20);
    return {imm20[19:0], rd[4:0], 7'b0110111};
endfunction

function automatic logic [31:0] addi(input int rd, input int rs1, input int imm);
    return iType(7'b0010011, rd, rs1, imm, 3'b000);
endfunction

function automatic logic [31:0] slti(input int rd, input int rs1, input int imm);
    return iType(7'b0010011, rd, rs1, imm, 3'b010);
endfunction

function automatic logic [31:0] xori(input int rd, input int rs1, input int imm);
    return iType(7'b0010011, rd, rs1, imm, 3'b100);
endfunction

function automatic logic [31:0] ori(input int rd, input int rs1, input int imm);
    return iType(7'b0010011, rd, rs1, imm, 3'b110);
endfunction

function automatic logic [31:0] andi(input int rd, input int rs1, input int imm);
    return iType(7'b0010011, rd, rs1, imm, 3'b111);
endfunction

function automatic logic [31:0] add(input int rd, input int rs1, input int rs2);
    return rType(7'h00, rd, rs1, rs2, 3'b000);
endfunction

function automatic logic [31:0] sub(input int rd, input int rs1, input int rs2);
    return rType(7'h20, rd, rs1, rs2, 3'b000);
endfunction

function automatic logic [31:0] slt(input int rd, input int rs1, input int rs2);
    return rType(7'h00, rd, rs1, rs2, 3'b010);
endfunction

function automatic logic [31:0] xorReg(input int rd, input int rs1, input int rs2);
    return rType(7'h00, rd, rs1, rs2, 3'b100);
endfunction

function automatic logic [31:0] orReg(input int rd, input int rs1, input int rs2);
    return rType(7'h00, rd, rs1, rs2, 3'b110);
endfunction

function automatic logic [31:0] andReg(input int rd, input int rs1, input int rs2);
    return rType(7'h00, rd, rs1, rs2, 3'b111);
endfunction

function automatic logic [31:0] lw(input int rd, input int rs1, input int imm);
    return iType(7'b0000011, rd, rs1, imm, 3'b010);
endfunction

// sw rs2, imm(rs1)
function automatic logic [31:0] sw(input int rs2, input int rs1, input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] beq(input int rs1, input int rs2, input int off);
    return bType(rs1, rs2, off, 3'b000);
endfunction

function automatic logic [31:0] bne(input int rs1, input int rs2, input int off);
    return bType(rs1, rs2, off, 3'b001);
endfunction

function automatic logic [31:0] jal(input int rd, input int off);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
endfunction

function automatic logic [31:0] jalr(input int rd, input int rs1, input int imm);
    return iType(7'b1100111, rd, rs1, imm, 3'b000);
endfunction

`endif

//--- tests/cpuTb.sv
`timescale 1ns/10ps

module cpuTb import cpuPkg::*; ();

    // Longest program and number of program runs bound the whole session
    localparam int MaxProgWords = 17;
    localparam int RunCount = 7;
    localparam int WatchdogCycles = RunCount * (MaxProgWords + 2 + 4 * MaxProgWords + 20) + 100;

    logic                    clk;
    logic                    rst;
    logic [XLen-1:0]         ioin;
    logic                    progWe;
    logic [IMemAddrBits-1:0] progAddr;
    logic [XLen-1:0]         progData;
    logic [XLen-1:0]         a0;

    logic [XLen-1:0] prog [$];
    logic [31:0]     lfsrState;
    int              errors;

    `include "cpuAsm.svh"

    cpu u_dut (
        .clk      (clk),
        .rst      (rst),
        .ioin     (ioin),
        .progWe   (progWe),
        .progAddr (progAddr),
        .progData (progData),
        .a0       (a0)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic lfsrBit();
        logic outBit;
        outBit = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (outBit)
            lfsrState = lfsrState ^ 32'h8020_0003;
        return outBit;
    endfunction

    function automatic logic [XLen-1:0] randomWord();
        logic [XLen-1:0] w;
        w = '0;
        for (int k = 0; k < XLen; k++)
            w = {w[XLen-2:0], lfsrBit()};
        return w;
    endfunction

    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    // Load prog while in reset, then let it run for the cycle bound
    task automatic runProgram();
        int cycles;
        cycles = 4 * prog.size() + 20;
        rst = 1'b1;
        for (int i = 0; i < prog.size(); i++)
        begin
            progWe = 1'b1;
            progAddr = IMemAddrBits'(i);
            progData = prog[i];
            nextCycle();
        end
        progWe = 1'b0;
        repeat (2) nextCycle();
        rst = 1'b0;
        repeat (cycles) nextCycle();
    endtask

    task automatic checkWord(input string what, input logic [XLen-1:0] got,
                             input logic [XLen-1:0] expected);
        if (got !== expected)
        begin
            errors++;
            $display("error at %0t ns: %s gave a0 = 0x%08h, expected 0x%08h",
                     $time, what, got, expected);
        end
    endtask

    // add x7 sees x5 in both memory and writeback, the memory copy is newer
    task automatic arithmeticChainTest();
        logic [XLen-1:0] r5, r6, r7, r8, r9, r11, r14, r15, r17;
        prog = '{addi(6, 0, -37), lui(5, 'hABCDE), addi(5, 5, 'h123), add(7, 5, 6),
                 sub(8, 7, 5), xorReg(9, 8, 7), slt(11, 8, 7), andi(12, 9, 'h7F0),
                 ori(13, 12, 5), xori(14, 13, -1), slti(15, 14, 0), add(10, 14, 15),
                 add(10, 10, 11), andReg(16, 7, 9), orReg(17, 16, 6), xorReg(10, 10, 17),
                 jal(0, 0)};
        runProgram();
        r5 = 32'hABCD_E123;
        r6 = 32'hFFFF_FFDB;
        r7 = r5 + r6;
        r8 = r7 - r5;
        r9 = r8 ^ r7;
        r11 = ($signed(r8) < $signed(r7)) ? 32'd1 : 32'd0;
        r14 = ~((r9 & 32'h7F0) | 32'h5);
        r15 = ($signed(r14) < 0) ? 32'd1 : 32'd0;
        r17 = (r7 & r9) | r6;
        checkWord("arithmetic chain", a0, (r14 + r15 + r11) ^ r17);
    endtask

    // Second load feeds the add at once
    task automatic storeLoadTest();
        prog = '{addi(5, 0, 'h100), lui(6, 'h12345), addi(6, 6, 'h678), addi(8, 0, -5),
                 sw(6, 5, 8), sw(8, 5, 12), lw(7, 5, 8), lw(9, 5, 12), add(10, 9, 7),
                 jal(0, 0)};
        runProgram();
        checkWord("store then load", a0, 32'h1234_5678 + 32'hFFFF_FFFB);
    endtask

    task automatic branchTest();
        prog = '{addi(10, 0, 0), addi(5, 0, 7), addi(6, 0, 7), beq(5, 6, 12),
                 addi(10, 10, 100), addi(10, 10, 200), addi(10, 10, 1), bne(5, 6, 8),
                 addi(10, 10, 2), addi(7, 0, 3), bne(5, 7, 12), addi(10, 10, 400),
                 addi(10, 10, 800), beq(5, 7, 8), addi(10, 10, 4), jal(0, 0)};
        runProgram();
        checkWord("branches", a0, 32'd1 + 32'd2 + 32'd4);
    endtask

    // jal at pc 0 links 4, jalr at pc 16 links 20 and lands on 32
    // The jal at 32 links 36 only if bit 0 of the jalr target was cleared
    task automatic jumpTest();
        prog = '{jal(1, 12), addi(10, 0, 100), addi(10, 0, 200), addi(5, 0, 30),
                 jalr(6, 5, 3), addi(10, 0, 300), addi(10, 0, 500), addi(10, 0, 700),
                 jal(7, 8), addi(10, 0, 900), add(10, 1, 6), add(10, 10, 7),
                 jal(0, 0)};
        runProgram();
        checkWord("jumps", a0, (32'd0 + 32'd4) + (32'd16 + 32'd4) + (32'd32 + 32'd4));
    endtask

    task automatic ioInputTest();
        logic [XLen-1:0] word;
        for (int n = 0; n < 2; n++)
        begin
            word = randomWord();
            ioin = word;
            // Store to io address must not alias data word 0
            prog = '{addi(5, 0, 'h400), addi(8, 0, 'h55), sw(8, 0, 0), sw(0, 5, 0),
                     lw(7, 5, 0), lw(9, 0, 0), add(10, 7, 9), jal(0, 0)};
            runProgram();
            checkWord("io input", a0, word + 32'h55);
        end
    endtask

    task automatic resetTest();
        prog = '{jal(0, 0)};
        runProgram();
        checkWord("reset", a0, 32'd0);
    endtask

    initial
    begin
        errors = 0;
        lfsrState = 32'h8907_ac77;
        rst = 1'b1;
        progWe = 1'b0;
        progAddr = '0;
        progData = '0;
        ioin = '0;
        repeat (2) nextCycle();
        arithmeticChainTest();
        storeLoadTest();
        branchTest();
        jumpTest();
        ioInputTest();
        resetTest();
        $display("errors: %0d", errors);
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

    initial
    begin
        repeat (WatchdogCycles) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles", WatchdogCycles);
        $display("Test failed");
        $finish;
    end

endmodule

//--- logic/cpu.sv
`timescale 1ns/10ps

module cpu import cpuPkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [XLen-1:0]         ioin,
    input  logic                    progWe,
    input  logic [IMemAddrBits-1:0] progAddr,
    input  logic [XLen-1:0]         progData,
    output logic [XLen-1:0]         a0
);

    ifIdT               ifId;
    idExT               idEx;
    exMemT              exMem;
    wbT                 wb;
    logic               redirect;
    logic [XLen-1:0]    redirectPc;
    logic               stallF;
    logic               stallD;
    logic               flushD;
    logic               flushE;
    fwdSelT             fwdA;
    fwdSelT             fwdB;
    logic [RegBits-1:0] rs1D;
    logic [RegBits-1:0] rs2D;

    fetchStage u_fetch (
        .clk        (clk),
        .rst        (rst),
        .stallF     (stallF),
        .stallD     (stallD),
        .flushD     (flushD),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .progWe     (progWe),
        .progAddr   (progAddr),
        .progData   (progData),
        .ifId       (ifId)
    );

    decodeStage u_decode (
        .clk    (clk),
        .rst    (rst),
        .ifId   (ifId),
        .wb     (wb),
        .flushE (flushE),
        .rs1D   (rs1D),
        .rs2D   (rs2D),
        .idEx   (idEx),
        .a0     (a0)
    );

    executeStage u_execute (
        .clk        (clk),
        .rst        (rst),
        .idEx       (idEx),
        .fwdA       (fwdA),
        .fwdB       (fwdB),
        .wb         (wb),
        .exMemFwd   (exMem),
        .exMem      (exMem),
        .redirect   (redirect),
        .redirectPc (redirectPc)
    );

    memoryStage u_memory (
        .clk   (clk),
        .rst   (rst),
        .exMem (exMem),
        .ioin  (ioin),
        .wb    (wb)
    );

    hazardUnit u_hazard (
        .idEx     (idEx),
        .exMem    (exMem),
        .wb       (wb),
        .rs1D     (rs1D),
        .rs2D     (rs2D),
        .redirect (redirect),
        .stallF   (stallF),
        .stallD   (stallD),
        .flushD   (flushD),
        .flushE   (flushE),
        .fwdA     (fwdA),
        .fwdB     (fwdB)
    );

endmodule

//--- logic/hazardUnit.sv
`timescale 1ns/10ps

module hazardUnit import cpuPkg::*; (
    input  idExT               idEx,
    input  exMemT              exMem,
    input  wbT                 wb,
    input  logic [RegBits-1:0] rs1D,
    input  logic [RegBits-1:0] rs2D,
    input  logic               redirect,
    output logic               stallF,
    output logic               stallD,
    output logic               flushD,
    output logic               flushE,
    output fwdSelT             fwdA,
    output fwdSelT             fwdB
);

    logic lwStall;

    // Memory stage is the younger producer, so it takes priority
    function automatic fwdSelT pickFwd(input logic [RegBits-1:0] rs, input exMemT m,
                                       input wbT w);
        if (rs == '0)
            return FwdNone;
        if (m.regWrite && m.rd == rs)
            return FwdFromMem;
        if (w.regWrite && w.rd == rs)
            return FwdFromWb;
        return FwdNone;
    endfunction

    assign fwdA = pickFwd(idEx.rs1, exMem, wb);
    assign fwdB = pickFwd(idEx.rs2, exMem, wb);

    assign lwStall = idEx.ctrl.regWrite && (idEx.ctrl.resultSrc == ResMem) &&
                     (idEx.rd != '0) && (idEx.rd == rs1D || idEx.rd == rs2D);

    assign stallF = lwStall;
    assign stallD = lwStall;
    assign flushD = redirect;
    assign flushE = lwStall || redirect;

endmodule

//--- logic/memoryStage.sv
`timescale 1ns/10ps

module memoryStage import cpuPkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  exMemT           exMem,
    input  logic [XLen-1:0] ioin,
    output wbT              wb
);

    logic [XLen-1:0]         dmem [DMemWords];
    logic [DMemAddrBits-1:0] wordAddr;
    logic                    isIo;
    logic [XLen-1:0]         readData;
    memWbT                   memWbD;
    memWbT                   memWb;

    assign wordAddr = exMem.aluResult[DMemAddrBits+1:2];
    assign isIo = (exMem.aluResult == IoAddr);

    // Stores to the io word go nowhere
    always_ff @(posedge clk)
    begin
        if (exMem.memWrite && !isIo)
            dmem[wordAddr] <= exMem.writeData;
    end

    assign readData = isIo ? ioin : dmem[wordAddr];

    always_comb
    begin
        memWbD.regWrite = exMem.regWrite;
        memWbD.resultSrc = exMem.resultSrc;
        memWbD.aluResult = exMem.aluResult;
        memWbD.readData = readData;
        memWbD.rd = exMem.rd;
        memWbD.pcPlus4 = exMem.pcPlus4;
    end

    stageReg #(.payloadT(memWbT)) u_memWbReg (
        .clk   (clk),
        .rst   (rst),
        .en    (1'b1),
        .flush (1'b0),
        .d     (memWbD),
        .q     (memWb)
    );

    // Writeback result select
    always_comb
    begin
        wb.regWrite = memWb.regWrite;
        wb.rd = memWb.rd;
        case (memWb.resultSrc)
            ResMem:     wb.result = memWb.readData;
            ResPcPlus4: wb.result = memWb.pcPlus4;
            default:    wb.result = memWb.aluResult;
        endcase
    end

endmodule

//--- logic/executeStage.sv
`timescale 1ns/10ps

module executeStage import cpuPkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  idExT            idEx,
    input  fwdSelT          fwdA,
    input  fwdSelT          fwdB,
    input  wbT              wb,
    input  exMemT           exMemFwd,
    output exMemT           exMem,
    output logic            redirect,
    output logic [XLen-1:0] redirectPc
);

    logic [XLen-1:0] srcA;
    logic [XLen-1:0] regB;
    logic [XLen-1:0] srcB;
    logic [XLen-1:0] aluResult;
    logic            equal;
    logic            taken;
    exMemT           exMemD;

    // Loads stall and links flush, so only ALU results forward from memory
    always_comb
    begin
        case (fwdA)
            FwdFromMem: srcA = exMemFwd.aluResult;
            FwdFromWb:  srcA = wb.result;
            default:    srcA = idEx.rd1;
        endcase
        case (fwdB)
            FwdFromMem: regB = exMemFwd.aluResult;
            FwdFromWb:  regB = wb.result;
            default:    regB = idEx.rd2;
        endcase
    end

    assign srcB = idEx.ctrl.aluSrc ? idEx.immExt : regB;

    always_comb
    begin
        case (idEx.ctrl.aluOp)
            AluSub:   aluResult = srcA - srcB;
            AluAnd:   aluResult = srcA & srcB;
            AluOr:    aluResult = srcA | srcB;
            AluXor:   aluResult = srcA ^ srcB;
            AluSlt:   aluResult = {{(XLen-1){1'b0}}, $signed(srcA) < $signed(srcB)};
            AluPassB: aluResult = srcB;
            default:  aluResult = srcA + srcB;
        endcase
    end

    // beq when equal, bne when not
    assign equal = (srcA == regB);
    assign taken = idEx.ctrl.branch && (equal ^ idEx.ctrl.branchNe);
    assign redirect = taken || idEx.ctrl.jump || idEx.ctrl.jalr;
    assign redirectPc = idEx.ctrl.jalr ? {aluResult[XLen-1:1], 1'b0}
                                       : idEx.pc + idEx.immExt;

    always_comb
    begin
        exMemD.regWrite = idEx.ctrl.regWrite;
        exMemD.resultSrc = idEx.ctrl.resultSrc;
        exMemD.memWrite = idEx.ctrl.memWrite;
        exMemD.aluResult = aluResult;
        exMemD.writeData = regB;
        exMemD.rd = idEx.rd;
        exMemD.pcPlus4 = idEx.pcPlus4;
    end

    stageReg #(.payloadT(exMemT)) u_exMemReg (
        .clk   (clk),
        .rst   (rst),
        .en    (1'b1),
        .flush (1'b0),
        .d     (exMemD),
        .q     (exMem)
    );

endmodule

//--- logic/decodeStage.sv
`timescale 1ns/10ps

module decodeStage import cpuPkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  ifIdT               ifId,
    input  wbT                 wb,
    input  logic               flushE,
    output logic [RegBits-1:0] rs1D,
    output logic [RegBits-1:0] rs2D,
    output idExT               idEx,
    output logic [XLen-1:0]    a0
);

    logic [XLen-1:0]    regs [32];
    logic [XLen-1:0]    instr;
    logic [6:0]         opcode;
    logic [2:0]         funct3;
    logic               funct7b5;
    logic [RegBits-1:0] rdD;
    ctrlT               ctrlD;
    logic [XLen-1:0]    immD;
    logic [XLen-1:0]    rd1D;
    logic [XLen-1:0]    rd2D;
    idExT               idExD;

    assign instr = ifId.instr;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7b5 = instr[30];
    assign rs1D = instr[19:15];
    assign rs2D = instr[24:20];
    assign rdD = instr[11:7];

    always_comb
    begin
        ctrlD = '0;
        immD = '0;
        case (opcode)
            OpLui:
            begin
                ctrlD.regWrite = 1'b1;
                ctrlD.aluSrc = 1'b1;
                ctrlD.aluOp = AluPassB;
                immD = {instr[31:12], 12'b0};
            end
            OpImm, OpReg:
            begin
                ctrlD.regWrite = 1'b1;
                ctrlD.aluSrc = (opcode == OpImm);
                immD = {{20{instr[31]}}, instr[31:20]};
                case (funct3)
                    3'b000: ctrlD.aluOp = (opcode == OpReg && funct7b5) ? AluSub : AluAdd;
                    3'b010: ctrlD.aluOp = AluSlt;
                    3'b100: ctrlD.aluOp = AluXor;
                    3'b110: ctrlD.aluOp = AluOr;
                    3'b111: ctrlD.aluOp = AluAnd;
                    // Shifts and sltu are outside the subset
                    default: ctrlD.regWrite = 1'b0;
                endcase
            end
            OpLoad:
            begin
                ctrlD.regWrite = 1'b1;
                ctrlD.resultSrc = ResMem;
                ctrlD.aluSrc = 1'b1;
                immD = {{20{instr[31]}}, instr[31:20]};
            end
            OpStore:
            begin
                ctrlD.memWrite = 1'b1;
                ctrlD.aluSrc = 1'b1;
                immD = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            OpBranch:
            begin
                // beq and bne only
                ctrlD.branch = (funct3 == 3'b000) || (funct3 == 3'b001);
                ctrlD.branchNe = funct3[0];
                ctrlD.aluOp = AluSub;
                immD = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            OpJal:
            begin
                ctrlD.regWrite = 1'b1;
                ctrlD.resultSrc = ResPcPlus4;
                ctrlD.jump = 1'b1;
                immD = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            OpJalr:
            begin
                ctrlD.regWrite = 1'b1;
                ctrlD.resultSrc = ResPcPlus4;
                ctrlD.jalr = 1'b1;
                ctrlD.aluSrc = 1'b1;
                immD = {{20{instr[31]}}, instr[31:20]};
            end
            default:
            begin
                ctrlD = '0;
            end
        endcase
    end

    // Register file, x0 never written
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (wb.regWrite && wb.rd != '0)
            regs[wb.rd] <= wb.result;
    end

    // Same-cycle writeback bypass
    assign rd1D = (rs1D == '0) ? '0 :
                  (wb.regWrite && wb.rd == rs1D) ? wb.result : regs[rs1D];
    assign rd2D = (rs2D == '0) ? '0 :
                  (wb.regWrite && wb.rd == rs2D) ? wb.result : regs[rs2D];
    assign a0 = regs[10];

    always_comb
    begin
        idExD.ctrl = ctrlD;
        idExD.rd1 = rd1D;
        idExD.rd2 = rd2D;
        idExD.pc = ifId.pc;
        idExD.pcPlus4 = ifId.pcPlus4;
        idExD.rs1 = rs1D;
        idExD.rs2 = rs2D;
        idExD.rd = rdD;
        idExD.immExt = immD;
    end

    stageReg #(.payloadT(idExT)) u_idExReg (
        .clk   (clk),
        .rst   (rst),
        .en    (1'b1),
        .flush (flushE),
        .d     (idExD),
        .q     (idEx)
    );

endmodule

//--- logic/fetchStage.sv
`timescale 1ns/10ps

module fetchStage import cpuPkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    stallF,
    input  logic                    stallD,
    input  logic                    flushD,
    input  logic                    redirect,
    input  logic [XLen-1:0]         redirectPc,
    input  logic                    progWe,
    input  logic [IMemAddrBits-1:0] progAddr,
    input  logic [XLen-1:0]         progData,
    output ifIdT                    ifId
);

    logic [XLen-1:0] imem [IMemWords];
    logic [XLen-1:0] pc;
    logic [XLen-1:0] pcPlus4;
    logic [XLen-1:0] instrF;
    ifIdT            ifIdD;

    // Program load port
    always_ff @(posedge clk)
    begin
        if (progWe)
            imem[progAddr] <= progData;
    end

    assign pcPlus4 = pc + XLen'(4);
    assign instrF = imem[pc[IMemAddrBits+1:2]];

    // Redirect wins over a load-use stall
    always_ff @(posedge clk)
    begin
        if (rst)
            pc <= '0;
        else if (redirect)
            pc <= redirectPc;
        else if (!stallF)
            pc <= pcPlus4;
    end

    always_comb
    begin
        ifIdD.instr = instrF;
        ifIdD.pc = pc;
        ifIdD.pcPlus4 = pcPlus4;
    end

    stageReg #(.payloadT(ifIdT)) u_ifIdReg (
        .clk   (clk),
        .rst   (rst),
        .en    (!stallD),
        .flush (flushD),
        .d     (ifIdD),
        .q     (ifId)
    );

endmodule

//--- logic/stageReg.sv
`timescale 1ns/10ps

module stageReg #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    en,
    input  logic    flush,
    input  payloadT d,
    output payloadT q
);

    // An all-zero payload is a bubble with no side effects
    always_ff @(posedge clk)
    begin
        if (rst || flush)
            q <= '0;
        else if (en)
            q <= d;
    end

endmodule

//--- logic/cpuPkg.sv
package cpuPkg;

    localparam int XLen = 32;
    localparam int RegBits = 5;
    localparam int IMemWords = 256;
    localparam int DMemWords = 256;
    localparam int IMemAddrBits = $clog2(IMemWords);
    localparam int DMemAddrBits = $clog2(DMemWords);
    localparam logic [XLen-1:0] IoAddr = 32'h0000_0400;

    // Major opcodes of the supported subset
    localparam logic [6:0] OpLui = 7'b0110111;
    localparam logic [6:0] OpImm = 7'b0010011;
    localparam logic [6:0] OpReg = 7'b0110011;
    localparam logic [6:0] OpLoad = 7'b0000011;
    localparam logic [6:0] OpStore = 7'b0100011;
    localparam logic [6:0] OpBranch = 7'b1100011;
    localparam logic [6:0] OpJal = 7'b1101111;
    localparam logic [6:0] OpJalr = 7'b1100111;

    typedef enum logic [2:0] {
        AluAdd,
        AluSub,
        AluAnd,
        AluOr,
        AluXor,
        AluSlt,
        AluPassB
    } aluOpT;

    typedef enum logic [1:0] {
        ResAlu = 2'b00,
        ResMem = 2'b01,
        ResPcPlus4 = 2'b10
    } resultSrcT;

    typedef enum logic [1:0] {
        FwdNone = 2'b00,
        FwdFromWb = 2'b01,
        FwdFromMem = 2'b10
    } fwdSelT;

    typedef struct packed {
        logic regWrite;
        resultSrcT resultSrc;
        logic memWrite;
        logic branch;
        logic branchNe;
        logic jump;
        logic jalr;
        logic aluSrc;
        aluOpT aluOp;
    } ctrlT;

    typedef struct packed {
        logic [XLen-1:0] instr;
        logic [XLen-1:0] pc;
        logic [XLen-1:0] pcPlus4;
    } ifIdT;

    typedef struct packed {
        ctrlT ctrl;
        logic [XLen-1:0] rd1;
        logic [XLen-1:0] rd2;
        logic [XLen-1:0] pc;
        logic [XLen-1:0] pcPlus4;
        logic [RegBits-1:0] rs1;
        logic [RegBits-1:0] rs2;
        logic [RegBits-1:0] rd;
        logic [XLen-1:0] immExt;
    } idExT;

    typedef struct packed {
        logic regWrite;
        resultSrcT resultSrc;
        logic memWrite;
        logic [XLen-1:0] aluResult;
        logic [XLen-1:0] writeData;
        logic [RegBits-1:0] rd;
        logic [XLen-1:0] pcPlus4;
    } exMemT;

    typedef struct packed {
        logic regWrite;
        resultSrcT resultSrc;
        logic [XLen-1:0] aluResult;
        logic [XLen-1:0] readData;
        logic [RegBits-1:0] rd;
        logic [XLen-1:0] pcPlus4;
    } memWbT;

    typedef struct packed {
        logic regWrite;
        logic [RegBits-1:0] rd;
        logic [XLen-1:0] result;
    } wbT;

endpackage
